/* sim.f */
rtl/aurora_reg_pkg.sv
rtl/aurora_link_pkg.sv
rtl/aurora_wb_target.sv
rtl/aurora_ctrl_regs.sv
rtl/aurora_cmd_steer.sv
rtl/aurora_link_wrap.sv
tb/tb_aurora_link_wrap.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, then scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f \
    --top-module tb_aurora_link_wrap -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "testbench reported failure, see sim.log"
    exit 1
fi
echo "testbench run clean"

/* tb/tb_aurora_link_wrap.sv */
`default_nettype none

module tb_aurora_link_wrap;

    localparam int NL = aurora_link_pkg::NUM_LINKS;
    localparam int RST_CYCLES = 8;
    localparam int N_LINK_WR = 24;
    localparam int N_GLOB = 4;
    localparam int N_DRP = 12;
    localparam int N_CMD = 40;
    // bus access at most 6 cycles, drp access at most 14, command pair under
    // random ready about 24, then doubled for margin
    localparam int TIMEOUT_CYCLES = 2 * (RST_CYCLES + (N_LINK_WR * 3 + N_GLOB * 9 + 16) * 6
        + N_DRP * 14 + N_CMD * 24);

    logic user_clk;
    logic user_aresetn;
    aurora_reg_pkg::wb_req_t wb_req;
    aurora_reg_pkg::wb_rsp_t wb_rsp;
    aurora_link_pkg::drp_req_t [NL-1:0] drp_req;
    aurora_link_pkg::drp_rsp_t [NL-1:0] drp_rsp;
    aurora_link_pkg::link_status_t [NL-1:0] link_status;
    logic [NL-1:0][15:0] link_dmon;
    aurora_link_pkg::link_cfg_t [NL-1:0] link_cfg;
    logic sys_reset;
    logic gt_reset;
    aurora_link_pkg::cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;
    aurora_link_pkg::ufc_t [NL-1:0] ufc;
    logic [NL-1:0] ufc_valid;
    logic [NL-1:0] ufc_ready;

    logic [31:0] rng_state = 32'hc7eea06b;
    int errors = 0;
    int checks = 0;
    int en_pulses = 0;
    logic [NL-1:0] en_vec;
    logic [NL-1:0] rdy_vec;
    // what the drp responder saw on the last en pulse
    logic [1:0] drp_seen_link;
    aurora_link_pkg::drp_req_t drp_seen;
    logic [15:0] drp_last_do;
    // shadow of the register file
    aurora_link_pkg::link_cfg_t shadow [NL];
    logic glob_rst;
    logic glob_gt;
    logic glob_dp;
    logic glob_le;

    aurora_link_wrap aurora_link_wrap_inst (
        .user_clk      (user_clk),
        .user_aresetn  (user_aresetn),
        .wb_req_i      (wb_req),
        .wb_rsp_o      (wb_rsp),
        .drp_req_o     (drp_req),
        .drp_rsp_i     (drp_rsp),
        .link_status_i (link_status),
        .link_dmon_i   (link_dmon),
        .link_cfg_o    (link_cfg),
        .sys_reset_o   (sys_reset),
        .gt_reset_o    (gt_reset),
        .cmd_i         (cmd),
        .cmd_valid_i   (cmd_valid),
        .cmd_ready_o   (cmd_ready),
        .ufc_o         (ufc),
        .ufc_valid_o   (ufc_valid),
        .ufc_ready_i   (ufc_ready)
    );

    initial begin
        user_clk = 1'b0;
        forever #20 user_clk = ~user_clk;
    end

    always_comb begin
        for (int i = 0; i < NL; i++) begin
            en_vec[i] = drp_req[i].en;
            rdy_vec[i] = drp_rsp[i].rdy;
        end
    end

    // en sampled mid-cycle, one count per cycle it is high
    always @(negedge user_clk) begin
        en_pulses = en_pulses + $countones(en_vec);
    end

    // control access acks one cycle after the request is first sampled
    ack_ctrl_timing: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        ($rose(wb_req.cyc) && !wb_req.adr[14]) |=> wb_rsp.ack)
        else begin
            errors++;
            $display("FAIL t=%0t wb_rsp_o.ack expected 1 got 0 (control access)", $time);
        end

    // drp access acks the cycle after rdy
    ack_after_rdy: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        (|rdy_vec) |=> wb_rsp.ack)
        else begin
            errors++;
            $display("FAIL t=%0t wb_rsp_o.ack expected 1 got 0 (after rdy)", $time);
        end

    valid_steer: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        ufc_valid == (cmd_valid ? (4'b0001 << cmd.dest) : 4'b0000))
        else begin
            errors++;
            $display("FAIL t=%0t ufc_valid_o expected %b got %b", $time,
                cmd_valid ? (4'b0001 << cmd.dest) : 4'b0000, ufc_valid);
        end

    // a stalled word and its size hold until the link takes it
    held_stable: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        (|(ufc_valid & ~ufc_ready)) |=> ($stable(ufc) && $stable(ufc_valid)))
        else begin
            errors++;
            $display("FAIL t=%0t ufc_o changed while held by back-pressure", $time);
        end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic next_drive_slot();
        @(posedge user_clk);
        #2;
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // word address: adr[13] global, adr[12:11] link, adr[10:2] register
    function automatic logic [14:0] link_reg_adr(input logic [1:0] link, input logic [8:0] idx);
        return {2'b00, link, idx, 2'b00};
    endfunction

    function automatic logic [31:0] exp_link_ctrl(input logic [1:0] link);
        aurora_link_pkg::link_cfg_t c;
        c = shadow[link];
        return {c.linkerr_reset, c.datapath_reset, 23'b0, c.loopback, c.powerdown,
            c.eyescan_reset, glob_gt, glob_rst};
    endfunction

    function automatic logic [31:0] exp_link_eye(input logic [1:0] link);
        aurora_link_pkg::link_cfg_t c;
        c = shadow[link];
        return {11'b0, c.txpostcursor, 3'b0, c.txprecursor, 4'b0, c.txdiffctrl};
    endfunction

    // one bus cycle, request held until ack, then one idle cycle
    task automatic bus_access(input logic we, input logic [3:0] sel, input logic [14:0] adr,
            input logic [31:0] wdat, output logic [31:0] rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.sel = sel;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge user_clk);
        while (!wb_rsp.ack) begin
            @(negedge user_clk);
        end
        rdat = wb_rsp.dat;
        next_drive_slot();
        wb_req = '0;
        next_drive_slot();
    endtask

    task automatic reg_write(input logic [14:0] adr, input logic [3:0] sel,
            input logic [31:0] wdat);
        logic [31:0] discard;
        bus_access(1'b1, sel, adr, wdat, discard);
    endtask

    task automatic reg_read_check(input string name, input logic [14:0] adr,
            input logic [31:0] expected);
        logic [31:0] rdat;
        bus_access(1'b0, 4'hf, adr, 32'h0, rdat);
        check_word(name, expected, rdat);
    endtask

    task automatic check_link(input logic [1:0] link);
        reg_read_check($sformatf("ctrl[%0d]", link), link_reg_adr(link, 9'd0),
            exp_link_ctrl(link));
        reg_read_check($sformatf("eye[%0d]", link), link_reg_adr(link, 9'd2),
            exp_link_eye(link));
    endtask

    // all links at once, so a write that leaks into another link shows up
    task automatic check_cfg_outputs();
        for (int i = 0; i < NL; i++) begin
            check_word($sformatf("link_cfg_o[%0d]", i), {11'b0, shadow[i]},
                {11'b0, link_cfg[i]});
        end
        check_word("sys_reset_o", {31'b0, glob_rst}, {31'b0, sys_reset});
        check_word("gt_reset_o", {31'b0, glob_gt}, {31'b0, gt_reset});
    endtask

    task automatic link_ctrl_write(input logic [1:0] link, input logic [3:0] sel,
            input logic [31:0] dat);
        // bits 0 and 1 of the link word are not stored per link
        if (sel[0]) begin
            shadow[link].eyescan_reset = dat[2];
            shadow[link].powerdown = dat[3];
            shadow[link].loopback = dat[6:4];
        end
        if (sel[3]) begin
            shadow[link].datapath_reset = dat[30];
            shadow[link].linkerr_reset = dat[31];
        end
        reg_write(link_reg_adr(link, 9'd0), sel, dat);
    endtask

    task automatic random_link_write();
        logic [31:0] r;
        logic [31:0] dat;
        logic [1:0] link;
        logic [3:0] sel;
        r = xorshift32();
        dat = xorshift32();
        link = r[1:0];
        sel = r[7:4];
        if (r[8]) begin
            link_ctrl_write(link, sel, dat);
        end else begin
            // eye scan, one field per byte lane
            if (sel[0]) shadow[link].txdiffctrl = dat[3:0];
            if (sel[1]) shadow[link].txprecursor = dat[12:8];
            if (sel[2]) shadow[link].txpostcursor = dat[20:16];
            reg_write(link_reg_adr(link, 9'd2), sel, dat);
        end
        check_cfg_outputs();
        check_link(link);
    endtask

    task automatic global_write_test();
        logic [31:0] r;
        logic [31:0] dat;
        logic [1:0] link;
        r = xorshift32();
        dat = xorshift32();
        if (r[0]) begin
            glob_rst = dat[0];
            glob_gt = dat[1];
        end
        if (r[3]) begin
            glob_dp = dat[30];
            glob_le = dat[31];
        end
        reg_write(15'h2000, r[3:0], dat);
        check_cfg_outputs();
        reg_read_check("glob_ctrl", 15'h2000, {glob_le, glob_dp, 28'b0, glob_gt, glob_rst});
        for (int i = 0; i < NL; i++) begin
            reg_read_check($sformatf("ctrl[%0d]", i), link_reg_adr(2'(i), 9'd0),
                exp_link_ctrl(2'(i)));
        end
        // try to flip the common resets through a link word
        link = r[5:4];
        dat = {r[31:9], 7'b0, ~glob_gt, ~glob_rst};
        link_ctrl_write(link, 4'b1001, dat);
        check_cfg_outputs();
        check_link(link);
    endtask

    task automatic status_test();
        logic [31:0] r;
        for (int i = 0; i < NL; i++) begin
            r = xorshift32();
            link_status[i] = r[11:0];
            link_dmon[i] = r[31:16];
        end
        for (int i = 0; i < NL; i++) begin
            reg_read_check($sformatf("stat[%0d]", i), link_reg_adr(2'(i), 9'd1),
                {20'b0, link_status[i]});
            reg_read_check($sformatf("dmon[%0d]", i), link_reg_adr(2'(i), 9'd3),
                {16'b0, link_dmon[i]});
        end
    endtask

    task automatic drp_access_test();
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] rdat;
        logic [1:0] link;
        logic [9:0] addr;
        logic [15:0] di;
        logic we;
        r = xorshift32();
        hi = xorshift32();
        link = r[1:0];
        addr = r[11:2];
        we = r[12];
        di = r[31:16];
        en_pulses = 0;
        bus_access(we, 4'hf, {1'b1, link, addr, 2'b00}, {hi[15:0], di}, rdat);
        check_word("drp en pulses", 32'd1, en_pulses);
        check_word("drp link", {30'b0, link}, {30'b0, drp_seen_link});
        check_word("drp_req_o.addr", {22'b0, addr}, {22'b0, drp_seen.addr});
        check_word("drp_req_o.di", {16'b0, di}, {16'b0, drp_seen.di});
        check_word("drp_req_o.we", {31'b0, we}, {31'b0, drp_seen.we});
        if (!we) begin
            check_word("wb_rsp_o.dat (drp)", {16'b0, drp_last_do}, rdat);
        end
    endtask

    // hold one word until the addressed link takes it, ready random per cycle
    task automatic send_word(input logic [31:0] data, input logic [1:0] dest,
            input logic last, input logic [2:0] exp_tsize);
        logic [31:0] r;
        logic taken;
        cmd.data = data;
        cmd.dest = dest;
        cmd.last = last;
        cmd_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            r = xorshift32();
            ufc_ready = r[3:0];
            @(negedge user_clk);
            check_word("ufc_o.tsize", {29'b0, exp_tsize}, {29'b0, ufc[dest].tsize});
            check_word("ufc_o.data", data, ufc[dest].data);
            check_word("ufc_o.last", {31'b0, last}, {31'b0, ufc[dest].last});
            // ready of the addressed link only
            check_word("cmd_ready_o", {31'b0, r[dest]}, {31'b0, cmd_ready});
            taken = cmd_ready;
            next_drive_slot();
        end
        cmd_valid = 1'b0;
    endtask

    task automatic send_command();
        logic [31:0] r;
        logic [1:0] dest;
        r = xorshift32();
        dest = r[1:0];
        if (r[2]) begin
            // write pair, size 011 on both words
            send_word(xorshift32(), dest, 1'b0, 3'b011);
            send_word(xorshift32(), dest, 1'b1, 3'b011);
        end else begin
            send_word(xorshift32(), dest, 1'b1, 3'b010);
        end
    endtask

    // answers each en after 1 to 8 cycles with random read data
    initial begin : drp_responder
        logic [31:0] r;
        int delay;
        forever begin
            @(negedge user_clk);
            if (|en_vec) begin
                for (int i = NL - 1; i >= 0; i--) begin
                    if (en_vec[i]) begin
                        drp_seen_link = 2'(i);
                        drp_seen = drp_req[i];
                    end
                end
                r = xorshift32();
                delay = 1 + int'(r[2:0]);
                drp_last_do = r[31:16];
                repeat (delay) next_drive_slot();
                drp_rsp[drp_seen_link].rdy = 1'b1;
                drp_rsp[drp_seen_link].dout = drp_last_do;
                next_drive_slot();
                drp_rsp[drp_seen_link].rdy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge user_clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d failures, %0d immediate checks run", errors, checks);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        user_aresetn = 1'b0;
        wb_req = '0;
        drp_rsp = '0;
        link_status = '0;
        link_dmon = '0;
        cmd = '0;
        cmd_valid = 1'b0;
        ufc_ready = '0;
        glob_rst = 1'b0;
        glob_gt = 1'b0;
        glob_dp = 1'b0;
        glob_le = 1'b0;
        for (int i = 0; i < NL; i++) begin
            shadow[i] = '0;
            shadow[i].txdiffctrl = 4'b1100;
        end
        repeat (RST_CYCLES) @(posedge user_clk);
        #2;
        user_aresetn = 1'b1;
        next_drive_slot();

        // reset values, eye word reads 0x0000000c
        check_cfg_outputs();
        for (int i = 0; i < NL; i++) begin
            check_link(2'(i));
        end
        repeat (N_LINK_WR) random_link_write();
        repeat (N_GLOB) global_write_test();
        status_test();
        repeat (N_DRP) drp_access_test();
        repeat (N_CMD) send_command();
        next_drive_slot();

        $display("errors: %0d failures, %0d immediate checks run", errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/aurora_link_wrap.sv */
`default_nettype none

module aurora_link_wrap (
    input  wire logic user_clk,
    input  wire logic user_aresetn,
    input  wire aurora_reg_pkg::wb_req_t wb_req_i,
    output aurora_reg_pkg::wb_rsp_t wb_rsp_o,
    output aurora_link_pkg::drp_req_t [aurora_link_pkg::NUM_LINKS-1:0] drp_req_o,
    input  wire aurora_link_pkg::drp_rsp_t [aurora_link_pkg::NUM_LINKS-1:0] drp_rsp_i,
    input  wire aurora_link_pkg::link_status_t [aurora_link_pkg::NUM_LINKS-1:0] link_status_i,
    input  wire logic [aurora_link_pkg::NUM_LINKS-1:0][aurora_link_pkg::DMON_W-1:0] link_dmon_i,
    output aurora_link_pkg::link_cfg_t [aurora_link_pkg::NUM_LINKS-1:0] link_cfg_o,
    output logic sys_reset_o,
    output logic gt_reset_o,
    input  wire aurora_link_pkg::cmd_t cmd_i,
    input  wire logic cmd_valid_i,
    output logic cmd_ready_o,
    output aurora_link_pkg::ufc_t [aurora_link_pkg::NUM_LINKS-1:0] ufc_o,
    output logic [aurora_link_pkg::NUM_LINKS-1:0] ufc_valid_o,
    input  wire logic [aurora_link_pkg::NUM_LINKS-1:0] ufc_ready_i
);

    // register read data and write strobe between target and register file
    logic [31:0] reg_rd_data;
    logic reg_wr;

    // bus decode, ack and drp forwarding
    aurora_wb_target u_wb_target (
        .user_clk      (user_clk),
        .user_aresetn  (user_aresetn),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .reg_rd_data_i (reg_rd_data),
        .reg_wr_o      (reg_wr),
        .drp_req_o     (drp_req_o),
        .drp_rsp_i     (drp_rsp_i)
    );

    // per-link and global control/status
    aurora_ctrl_regs u_ctrl_regs (
        .user_clk      (user_clk),
        .user_aresetn  (user_aresetn),
        .wb_req_i      (wb_req_i),
        .reg_wr_i      (reg_wr),
        .reg_rd_data_o (reg_rd_data),
        .link_status_i (link_status_i),
        .link_dmon_i   (link_dmon_i),
        .link_cfg_o    (link_cfg_o),
        .sys_reset_o   (sys_reset_o),
        .gt_reset_o    (gt_reset_o)
    );

    // command stream to the ufc ports
    aurora_cmd_steer u_cmd_steer (
        .user_clk     (user_clk),
        .user_aresetn (user_aresetn),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .ufc_o        (ufc_o),
        .ufc_valid_o  (ufc_valid_o),
        .ufc_ready_i  (ufc_ready_i)
    );

endmodule

`default_nettype wire

/* rtl/aurora_cmd_steer.sv */
`default_nettype none

module aurora_cmd_steer (
    input  wire logic user_clk,
    input  wire logic user_aresetn,
    input  wire aurora_link_pkg::cmd_t cmd_i,
    input  wire logic cmd_valid_i,
    output logic cmd_ready_o,
    output aurora_link_pkg::ufc_t [aurora_link_pkg::NUM_LINKS-1:0] ufc_o,
    output logic [aurora_link_pkg::NUM_LINKS-1:0] ufc_valid_o,
    input  wire logic [aurora_link_pkg::NUM_LINKS-1:0] ufc_ready_i
);

    logic second_q;
    logic tsize_lsb;
    logic accept;

    // ufc messages are 4 bytes (read) or 8 bytes (write pair)
    // read : last=1 on the first word -> 010
    // write: last=0 then last=1 with second_q set -> 011 both times
    assign tsize_lsb = cmd_valid_i && (cmd_i.last != !second_q);

    // ready comes back from the addressed link only
    assign cmd_ready_o = ufc_ready_i[cmd_i.dest];
    assign accept = cmd_valid_i && cmd_ready_o;

    // valid steered by dest, payload broadcast
    always_comb begin
        for (int i = 0; i < aurora_link_pkg::NUM_LINKS; i++) begin
            ufc_valid_o[i] = cmd_valid_i &&
                (cmd_i.dest == i[aurora_link_pkg::LINK_SEL_W-1:0]);
            ufc_o[i].data = cmd_i.data;
            ufc_o[i].last = cmd_i.last;
            ufc_o[i].tsize = {aurora_link_pkg::UFC_TSIZE_HI, tsize_lsb};
        end
    end

    // second-word flag only moves on an accepted word
    // held words under back-pressure leave it alone
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            second_q <= 1'b0;
        end else if (accept) begin
            second_q <= !cmd_i.last;
        end
    end

    // after a first write word the next word has to close the pair
    a_second_is_last: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        (second_q && cmd_valid_i) |-> cmd_i.last);

endmodule

`default_nettype wire

/* rtl/aurora_ctrl_regs.sv */
`default_nettype none

module aurora_ctrl_regs (
    input  wire logic user_clk,
    input  wire logic user_aresetn,
    input  wire aurora_reg_pkg::wb_req_t wb_req_i,
    input  wire logic reg_wr_i,
    output logic [31:0] reg_rd_data_o,
    input  wire aurora_link_pkg::link_status_t [aurora_link_pkg::NUM_LINKS-1:0] link_status_i,
    input  wire logic [aurora_link_pkg::NUM_LINKS-1:0][aurora_link_pkg::DMON_W-1:0] link_dmon_i,
    output aurora_link_pkg::link_cfg_t [aurora_link_pkg::NUM_LINKS-1:0] link_cfg_o,
    output logic sys_reset_o,
    output logic gt_reset_o
);

    aurora_link_pkg::link_cfg_t [aurora_link_pkg::NUM_LINKS-1:0] cfg_q;
    aurora_reg_pkg::glob_ctrl_word_t glob_q;
    aurora_reg_pkg::ctrl_word_u wr_ctrl;
    aurora_reg_pkg::eye_word_t wr_eye;
    aurora_reg_pkg::ctrl_word_u rd_ctrl;
    aurora_reg_pkg::eye_word_t rd_eye;
    logic ind_space;
    logic [aurora_link_pkg::LINK_SEL_W-1:0] link_sel;
    logic [aurora_reg_pkg::REG_OFS_W-1:0] ofs;

    // individual space below 0x2000, four 0x800 blocks
    assign ind_space = !wb_req_i.adr[13];
    assign link_sel = wb_req_i.adr[12:11];
    assign ofs = {wb_req_i.adr[10:2], 2'b00};

    // the same write word seen both ways
    assign wr_ctrl = wb_req_i.dat;
    assign wr_eye = wb_req_i.dat;

    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            glob_q <= '0;
            for (int i = 0; i < aurora_link_pkg::NUM_LINKS; i++) begin
                cfg_q[i] <= '0;
                cfg_q[i].txdiffctrl <= aurora_reg_pkg::TXDIFFCTRL_DEFAULT;
            end
        end else if (reg_wr_i) begin
            if (ind_space) begin
                for (int i = 0; i < aurora_link_pkg::NUM_LINKS; i++) begin
                    if (link_sel == i[aurora_link_pkg::LINK_SEL_W-1:0]) begin
                        // bits 0 and 1 belong to the global word, dropped here
                        if (ofs == aurora_reg_pkg::REG_CTRL_OFS) begin
                            if (wb_req_i.sel[0]) begin
                                cfg_q[i].eyescan_reset <= wr_ctrl.link.eyescan_reset;
                                cfg_q[i].powerdown <= wr_ctrl.link.powerdown;
                                cfg_q[i].loopback <= wr_ctrl.link.loopback;
                            end
                            if (wb_req_i.sel[3]) begin
                                cfg_q[i].datapath_reset <= wr_ctrl.link.datapath_reset;
                                cfg_q[i].linkerr_reset <= wr_ctrl.link.linkerr_reset;
                            end
                        end
                        // eye scan, one field per byte lane
                        if (ofs == aurora_reg_pkg::REG_EYE_OFS) begin
                            if (wb_req_i.sel[0]) begin
                                cfg_q[i].txdiffctrl <= wr_eye.txdiffctrl;
                            end
                            if (wb_req_i.sel[1]) begin
                                cfg_q[i].txprecursor <= wr_eye.txprecursor;
                            end
                            if (wb_req_i.sel[2]) begin
                                cfg_q[i].txpostcursor <= wr_eye.txpostcursor;
                            end
                        end
                    end
                end
            end else if (ofs == aurora_reg_pkg::REG_CTRL_OFS) begin
                // global word, common resets in byte 0
                if (wb_req_i.sel[0]) begin
                    glob_q.reset <= wr_ctrl.glob.reset;
                    glob_q.gt_reset <= wr_ctrl.glob.gt_reset;
                end
                // stored for readback only
                if (wb_req_i.sel[3]) begin
                    glob_q.datapath_reset <= wr_ctrl.glob.datapath_reset;
                    glob_q.linkerr_reset <= wr_ctrl.glob.linkerr_reset;
                end
            end
        end
    end

    // link control readback, common resets mirrored into bits 0 and 1
    always_comb begin
        rd_ctrl = '0;
        rd_ctrl.link.reset = glob_q.reset;
        rd_ctrl.link.gt_reset = glob_q.gt_reset;
        rd_ctrl.link.eyescan_reset = cfg_q[link_sel].eyescan_reset;
        rd_ctrl.link.powerdown = cfg_q[link_sel].powerdown;
        rd_ctrl.link.loopback = cfg_q[link_sel].loopback;
        rd_ctrl.link.datapath_reset = cfg_q[link_sel].datapath_reset;
        rd_ctrl.link.linkerr_reset = cfg_q[link_sel].linkerr_reset;
        rd_eye = '0;
        rd_eye.txdiffctrl = cfg_q[link_sel].txdiffctrl;
        rd_eye.txprecursor = cfg_q[link_sel].txprecursor;
        rd_eye.txpostcursor = cfg_q[link_sel].txpostcursor;
    end

    // read mux, anything unmapped reads zero
    always_comb begin
        reg_rd_data_o = '0;
        if (ind_space) begin
            case (ofs)
                aurora_reg_pkg::REG_CTRL_OFS: reg_rd_data_o = rd_ctrl;
                aurora_reg_pkg::REG_STAT_OFS: begin
                    reg_rd_data_o[$bits(aurora_link_pkg::link_status_t)-1:0] =
                        link_status_i[link_sel];
                end
                aurora_reg_pkg::REG_EYE_OFS: reg_rd_data_o = rd_eye;
                aurora_reg_pkg::REG_DMON_OFS: begin
                    reg_rd_data_o[aurora_link_pkg::DMON_W-1:0] = link_dmon_i[link_sel];
                end
                default: begin
                    reg_rd_data_o = '0;
                end
            endcase
        end else if (ofs == aurora_reg_pkg::REG_CTRL_OFS) begin
            reg_rd_data_o = glob_q;
        end
    end

    assign link_cfg_o = cfg_q;
    assign sys_reset_o = glob_q.reset;
    assign gt_reset_o = glob_q.gt_reset;

    // the target only strobes writes for control space
    a_wr_ctrl_only: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        reg_wr_i |-> !wb_req_i.adr[14]);

endmodule

`default_nettype wire

/* rtl/aurora_wb_target.sv */
`default_nettype none

module aurora_wb_target (
    input  wire logic user_clk,
    input  wire logic user_aresetn,
    input  wire aurora_reg_pkg::wb_req_t wb_req_i,
    output aurora_reg_pkg::wb_rsp_t wb_rsp_o,
    input  wire logic [31:0] reg_rd_data_i,
    output logic reg_wr_o,
    output aurora_link_pkg::drp_req_t [aurora_link_pkg::NUM_LINKS-1:0] drp_req_o,
    input  wire aurora_link_pkg::drp_rsp_t [aurora_link_pkg::NUM_LINKS-1:0] drp_rsp_i
);

    logic [aurora_reg_pkg::ST_W-1:0] state_q;
    logic [31:0] dat_q;
    logic req;
    logic drp_space;
    logic drp_start;
    logic drp_rdy;
    logic [aurora_link_pkg::LINK_SEL_W-1:0] drp_sel;
    logic [aurora_link_pkg::NUM_LINKS-1:0] drp_en;

    assign req = wb_req_i.cyc && wb_req_i.stb;
    // adr[14] alone splits control space from drp space
    assign drp_space = wb_req_i.adr[14];
    // each drp port owns a 4k window, picked by adr[13:12]
    assign drp_sel = wb_req_i.adr[13:12];
    assign drp_start = (state_q == aurora_reg_pkg::ST_IDLE) && req && drp_space;
    assign drp_rdy = drp_rsp_i[drp_sel].rdy;

    // one en pulse on the addressed port, the rest is shared
    always_comb begin
        for (int i = 0; i < aurora_link_pkg::NUM_LINKS; i++) begin
            drp_en[i] = drp_start && (drp_sel == i[aurora_link_pkg::LINK_SEL_W-1:0]);
            drp_req_o[i].en = drp_en[i];
            drp_req_o[i].we = wb_req_i.we;
            drp_req_o[i].addr = wb_req_i.adr[2 +: aurora_link_pkg::DRP_ADR_W];
            drp_req_o[i].di = wb_req_i.dat[aurora_link_pkg::DRP_DAT_W-1:0];
        end
    end

    // idle -> ack for control space
    // idle -> drp wait -> ack for drp space, latency set by rdy
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            state_q <= aurora_reg_pkg::ST_IDLE;
        end else begin
            case (state_q)
                aurora_reg_pkg::ST_IDLE: begin
                    if (req) begin
                        if (drp_space) begin
                            state_q <= aurora_reg_pkg::ST_DRP_WAIT;
                        end else begin
                            state_q <= aurora_reg_pkg::ST_ACK;
                        end
                    end
                end
                aurora_reg_pkg::ST_ACK: begin
                    state_q <= aurora_reg_pkg::ST_IDLE;
                end
                aurora_reg_pkg::ST_DRP_WAIT: begin
                    if (drp_rdy) begin
                        state_q <= aurora_reg_pkg::ST_ACK;
                    end
                end
                default: begin
                    state_q <= aurora_reg_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // read data capture
    // control space in idle, drp space on rdy (zero-extended)
    always_ff @(posedge user_clk) begin
        if (req && !wb_req_i.we) begin
            if (state_q == aurora_reg_pkg::ST_IDLE && !drp_space) begin
                dat_q <= reg_rd_data_i;
            end else if (state_q == aurora_reg_pkg::ST_DRP_WAIT && drp_rdy) begin
                dat_q <= {16'h0000, drp_rsp_i[drp_sel].dout};
            end
        end
    end

    assign wb_rsp_o.ack = (state_q == aurora_reg_pkg::ST_ACK);
    assign wb_rsp_o.dat = dat_q;

    // write lands at the edge that closes the ack cycle
    assign reg_wr_o = wb_rsp_o.ack && wb_req_i.we && !drp_space;

    // every access returns to idle after ack
    a_ack_single: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        wb_rsp_o.ack |=> !wb_rsp_o.ack);

    // never two drp ports started together
    a_drp_en_onehot: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        $onehot0(drp_en));

endmodule

`default_nettype wire

/* rtl/aurora_link_pkg.sv */
`default_nettype none

package aurora_link_pkg;

    localparam int NUM_LINKS = 4;
    localparam int LINK_SEL_W = 2;
    localparam int DRP_ADR_W = 10;
    localparam int DRP_DAT_W = 16;
    localparam int DMON_W = 16;
    localparam int CMD_DAT_W = 32;

    // upper two bits of the ufc size are always 01
    localparam logic [1:0] UFC_TSIZE_HI = 2'b01;

    // status bits reported by one link
    typedef struct packed {
        logic lane_up;
        logic channel_up;
        logic gt_powergood;
        logic tx_lock;
        logic tx_resetdone;
        logic rx_resetdone;
        logic link_reset;
        logic sys_reset;
        logic hard_err;
        logic soft_err;
        logic frame_err;
        logic bufg_gt_clr;
    } link_status_t;

    // settings driven into one link
    typedef struct packed {
        logic eyescan_reset;
        logic powerdown;
        logic [2:0] loopback;
        logic datapath_reset;
        logic linkerr_reset;
        logic [3:0] txdiffctrl;
        logic [4:0] txprecursor;
        logic [4:0] txpostcursor;
    } link_cfg_t;

    typedef struct packed {
        logic en;
        logic we;
        logic [DRP_ADR_W-1:0] addr;
        logic [DRP_DAT_W-1:0] di;
    } drp_req_t;

    // read data from the port, named dout since do is a keyword
    typedef struct packed {
        logic rdy;
        logic [DRP_DAT_W-1:0] dout;
    } drp_rsp_t;

    typedef struct packed {
        logic [CMD_DAT_W-1:0] data;
        logic [LINK_SEL_W-1:0] dest;
        logic last;
    } cmd_t;

    typedef struct packed {
        logic [CMD_DAT_W-1:0] data;
        logic last;
        logic [2:0] tsize;
    } ufc_t;

endpackage

`default_nettype wire

/* rtl/aurora_reg_pkg.sv */
`default_nettype none

package aurora_reg_pkg;

    // bus geometry
    localparam int WB_ADR_W = 15;
    localparam int WB_DAT_W = 32;

    // byte offsets inside one control/status block, built from adr[10:2]
    localparam int REG_OFS_W = 11;
    localparam logic [REG_OFS_W-1:0] REG_CTRL_OFS = 11'h000;
    localparam logic [REG_OFS_W-1:0] REG_STAT_OFS = 11'h004;
    localparam logic [REG_OFS_W-1:0] REG_EYE_OFS = 11'h008;
    localparam logic [REG_OFS_W-1:0] REG_DMON_OFS = 11'h00C;

    // bus target state encoding
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
    localparam logic [ST_W-1:0] ST_ACK = 2'd1;
    localparam logic [ST_W-1:0] ST_DRP_WAIT = 2'd2;

    // txdiffctrl comes out of reset at 1100
    localparam logic [3:0] TXDIFFCTRL_DEFAULT = 4'b1100;

    // request side, held by the initiator until ack
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [3:0] sel;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // per-link control word
    // reset and gt_reset are common to all links and the global word
    typedef struct packed {
        logic linkerr_reset;
        logic datapath_reset;
        logic [22:0] rsvd;
        logic [2:0] loopback;
        logic powerdown;
        logic eyescan_reset;
        logic gt_reset;
        logic reset;
    } link_ctrl_word_t;

    // global control word at offset 0 of the global space
    typedef struct packed {
        logic linkerr_reset;
        logic datapath_reset;
        logic [27:0] rsvd;
        logic gt_reset;
        logic reset;
    } glob_ctrl_word_t;

    // same offset, decoded per link or globally
    typedef union packed {
        link_ctrl_word_t link;
        glob_ctrl_word_t glob;
    } ctrl_word_u;

    // transmit driver settings
    typedef struct packed {
        logic [10:0] rsvd_hi;
        logic [4:0] txpostcursor;
        logic [2:0] rsvd_mid;
        logic [4:0] txprecursor;
        logic [3:0] rsvd_lo;
        logic [3:0] txdiffctrl;
    } eye_word_t;

endpackage

`default_nettype wire
